//--- hdl/cache_dir_pkg.sv
`default_nettype none

package cache_dir_pkg;

    // ----------------------------------------------------------------------
    // directory geometry
    // ----------------------------------------------------------------------
    localparam int unsigned set_num    = 64;
    localparam int unsigned way_num    = 4;
    localparam int unsigned rrpv_width = 2;
    localparam int unsigned tag_width  = 12;

    localparam int unsigned index_width = $clog2(set_num);  // 6 for 64 sets
    localparam int unsigned way_width   = $clog2(way_num);  // 2 for 4 ways

    // ----------------------------------------------------------------------
    // re-reference prediction values
    // ----------------------------------------------------------------------
    localparam logic [rrpv_width-1:0] rrpv_max    = '1;              // distant re-reference
    localparam logic [rrpv_width-1:0] rrpv_insert = rrpv_max - 1'b1; // new lines land here

endpackage

`default_nettype wire

//--- hdl/tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module tag_store (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [cache_dir_pkg::index_width-1:0] rd_index_0,
    input  logic [cache_dir_pkg::index_width-1:0] rd_index_1,
    output logic [cache_dir_pkg::way_num-1:0]     rd_valid_0,
    output logic [cache_dir_pkg::way_num-1:0]     rd_valid_1,
    output logic [cache_dir_pkg::tag_width-1:0]   rd_tags_0 [cache_dir_pkg::way_num],
    output logic [cache_dir_pkg::tag_width-1:0]   rd_tags_1 [cache_dir_pkg::way_num],
    input  logic                                  fill_en_0,
    input  logic                                  fill_en_1,
    input  logic [cache_dir_pkg::index_width-1:0] fill_index_0,
    input  logic [cache_dir_pkg::index_width-1:0] fill_index_1,
    input  logic [cache_dir_pkg::way_width-1:0]   fill_way_0,
    input  logic [cache_dir_pkg::way_width-1:0]   fill_way_1,
    input  logic [cache_dir_pkg::tag_width-1:0]   fill_tag_0,
    input  logic [cache_dir_pkg::tag_width-1:0]   fill_tag_1
);
    import cache_dir_pkg::*;

    logic [way_num-1:0]   valid_q [set_num];
    logic [tag_width-1:0] tag_q   [set_num][way_num];

    // ----------------------------------------------------------------------
    // read ports, combinational
    // ----------------------------------------------------------------------
    always_comb begin
        rd_valid_0 = valid_q[rd_index_0];
        rd_valid_1 = valid_q[rd_index_1];
        for (int w = 0; w < way_num; w++) begin
            rd_tags_0[w] = tag_q[rd_index_0][w];
            rd_tags_1[w] = tag_q[rd_index_1][w];
        end
    end

    // ----------------------------------------------------------------------
    // fill ports
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < set_num; s++) begin
                valid_q[s] <= '0;                   // empty directory
            end
        end else begin
            if (fill_en_0) begin
                valid_q[fill_index_0][fill_way_0] <= 1'b1;
            end
            if (fill_en_1) begin
                valid_q[fill_index_1][fill_way_1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_0) begin
            tag_q[fill_index_0][fill_way_0] <= fill_tag_0;
        end
        if (fill_en_1) begin
            tag_q[fill_index_1][fill_way_1] <= fill_tag_1;  // port 1 wins same slot
        end
    end

endmodule

`default_nettype wire

//--- hdl/tag_match.sv
`timescale 1ns/100ps
`default_nettype none

module tag_match (
    input  logic [cache_dir_pkg::tag_width-1:0] req_tag,
    input  logic [cache_dir_pkg::way_num-1:0]   way_valid,
    input  logic [cache_dir_pkg::tag_width-1:0] way_tags [cache_dir_pkg::way_num],
    output logic                                hit,
    output logic [cache_dir_pkg::way_width-1:0] hit_way
);
    import cache_dir_pkg::*;

    logic [way_num-1:0] match_vec;

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            match_vec[w] = way_valid[w] && (way_tags[w] == req_tag);
        end
    end

    assign hit = |match_vec;

    // onehot to binary, or-reduced per bit
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num; w++) begin
            if (match_vec[w]) begin
                hit_way = hit_way | w[way_width-1:0];
            end
        end
    end

    // a tag lives in at most one way of a set
    always_comb begin
        if (!$isunknown(match_vec)) begin
            assert ($onehot0(match_vec))
            else $error("%0t tag_match: several ways match, vector %b", $time, match_vec);
        end
    end

endmodule

`default_nettype wire

//--- hdl/srrip_policy.sv
`timescale 1ns/100ps
`default_nettype none

module srrip_policy (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_vld_0,
    input  logic                                  req_vld_1,
    input  logic [cache_dir_pkg::index_width-1:0] req_index_0,
    input  logic [cache_dir_pkg::index_width-1:0] req_index_1,
    input  logic                                  hit_0,
    input  logic                                  hit_1,
    input  logic [cache_dir_pkg::way_width-1:0]   hit_way_0,
    input  logic [cache_dir_pkg::way_width-1:0]   hit_way_1,
    output logic [cache_dir_pkg::way_width-1:0]   victim_way_0,
    output logic [cache_dir_pkg::way_width-1:0]   victim_way_1
);
    import cache_dir_pkg::*;

    logic [way_num-1:0][rrpv_width-1:0] rrpv_q [set_num];

    logic                               miss_0;
    logic                               miss_1;
    logic                               same_set;     // port 0 touches port 1's set
    logic [way_num-1:0][rrpv_width-1:0] set_0;
    logic [way_num-1:0][rrpv_width-1:0] aged_0;
    logic [way_num-1:0][rrpv_width-1:0] next_0;
    logic [way_num-1:0][rrpv_width-1:0] base_1;
    logic [way_num-1:0][rrpv_width-1:0] aged_1;
    logic [way_num-1:0][rrpv_width-1:0] next_1;
    logic [way_num-1:0]                 skip_1;

    // ----------------------------------------------------------------------
    // victim search
    // lifts all scanned ways by the gap between the set's highest value
    // and rrpv_max, equal to repeated single-step aging, then picks the
    // lowest scanned way at rrpv_max. skipped ways are left as they are
    // ----------------------------------------------------------------------
    function automatic logic [way_width-1:0] age_pick(
        input  logic [way_num-1:0][rrpv_width-1:0] vals,
        input  logic [way_num-1:0]                 skip,
        output logic [way_num-1:0][rrpv_width-1:0] aged
    );
        logic [rrpv_width-1:0] top;
        logic [rrpv_width-1:0] gap;
        logic                  found;
        top = '0;
        for (int w = 0; w < way_num; w++) begin
            if (!skip[w] && (vals[w] > top)) begin
                top = vals[w];
            end
        end
        gap      = rrpv_max - top;                // zero if already at max
        aged     = vals;
        age_pick = '0;
        found    = 1'b0;
        for (int w = 0; w < way_num; w++) begin
            if (!skip[w]) begin
                aged[w] = vals[w] + gap;
            end
            if (!found && !skip[w] && (aged[w] == rrpv_max)) begin
                age_pick = w[way_width-1:0];
                found    = 1'b1;
            end
        end
    endfunction

    // ----------------------------------------------------------------------
    // per-port next values
    // ----------------------------------------------------------------------
    always_comb begin
        miss_0   = req_vld_0 && !hit_0;
        miss_1   = req_vld_1 && !hit_1;
        same_set = req_vld_0 && (req_index_0 == req_index_1);

        // port 0 works on the stored set
        set_0        = rrpv_q[req_index_0];
        victim_way_0 = age_pick(set_0, '0, aged_0);
        if (hit_0) begin
            next_0            = set_0;
            next_0[hit_way_0] = '0;               // promote
        end else begin
            next_0               = aged_0;
            next_0[victim_way_0] = rrpv_insert;
        end

        // port 1 sees port 0's result when both share a set
        base_1 = same_set ? next_0 : rrpv_q[req_index_1];
        skip_1 = '0;
        if (same_set && miss_0) begin
            skip_1[victim_way_0] = 1'b1;          // keep port 0's victim
        end
        victim_way_1 = age_pick(base_1, skip_1, aged_1);
        if (hit_1) begin
            next_1            = base_1;
            next_1[hit_way_1] = '0;
        end else begin
            next_1               = aged_1;
            next_1[victim_way_1] = rrpv_insert;
        end
    end

    // ----------------------------------------------------------------------
    // value array
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < set_num; s++) begin
                rrpv_q[s] <= {way_num{rrpv_max}};
            end
        end else begin
            if (req_vld_0) begin
                rrpv_q[req_index_0] <= next_0;
            end
            if (req_vld_1) begin
                rrpv_q[req_index_1] <= next_1;    // already holds port 0's update
            end
        end
    end

    // a double miss in one set must install into two different ways
    a_distinct_victims: assert property (
        @(posedge clk) disable iff (!rst_n)
        (same_set && miss_0 && miss_1) |-> (victim_way_0 != victim_way_1)
    ) else $error("%0t srrip_policy: both ports chose way %0d", $time, victim_way_0);

endmodule

`default_nettype wire

//--- hdl/cache_dir_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_dir_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_vld_0,
    input  logic [cache_dir_pkg::index_width-1:0] req_index_0,
    input  logic [cache_dir_pkg::tag_width-1:0]   req_tag_0,
    input  logic                                  req_vld_1,
    input  logic [cache_dir_pkg::index_width-1:0] req_index_1,
    input  logic [cache_dir_pkg::tag_width-1:0]   req_tag_1,
    output logic                                  resp_vld_0,
    output logic                                  resp_hit_0,
    output logic [cache_dir_pkg::way_width-1:0]   resp_way_0,
    output logic                                  resp_vld_1,
    output logic                                  resp_hit_1,
    output logic [cache_dir_pkg::way_width-1:0]   resp_way_1
);
    import cache_dir_pkg::*;

    logic [way_num-1:0]   rd_valid_0;
    logic [way_num-1:0]   rd_valid_1;
    logic [tag_width-1:0] rd_tags_0 [way_num];
    logic [tag_width-1:0] rd_tags_1 [way_num];
    logic                 hit_0;
    logic                 hit_1;
    logic [way_width-1:0] hit_way_0;
    logic [way_width-1:0] hit_way_1;
    logic [way_width-1:0] victim_way_0;
    logic [way_width-1:0] victim_way_1;
    logic                 fill_en_0;
    logic                 fill_en_1;

    assign fill_en_0 = req_vld_0 && !hit_0;       // install on miss
    assign fill_en_1 = req_vld_1 && !hit_1;

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    tag_store u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index_0   (req_index_0),
        .rd_index_1   (req_index_1),
        .rd_valid_0   (rd_valid_0),
        .rd_valid_1   (rd_valid_1),
        .rd_tags_0    (rd_tags_0),
        .rd_tags_1    (rd_tags_1),
        .fill_en_0    (fill_en_0),
        .fill_en_1    (fill_en_1),
        .fill_index_0 (req_index_0),
        .fill_index_1 (req_index_1),
        .fill_way_0   (victim_way_0),
        .fill_way_1   (victim_way_1),
        .fill_tag_0   (req_tag_0),
        .fill_tag_1   (req_tag_1)
    );

    tag_match u_match_0 (
        .req_tag   (req_tag_0),
        .way_valid (rd_valid_0),
        .way_tags  (rd_tags_0),
        .hit       (hit_0),
        .hit_way   (hit_way_0)
    );

    tag_match u_match_1 (
        .req_tag   (req_tag_1),
        .way_valid (rd_valid_1),
        .way_tags  (rd_tags_1),
        .hit       (hit_1),
        .hit_way   (hit_way_1)
    );

    srrip_policy u_policy (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld_0    (req_vld_0),
        .req_vld_1    (req_vld_1),
        .req_index_0  (req_index_0),
        .req_index_1  (req_index_1),
        .hit_0        (hit_0),
        .hit_1        (hit_1),
        .hit_way_0    (hit_way_0),
        .hit_way_1    (hit_way_1),
        .victim_way_0 (victim_way_0),
        .victim_way_1 (victim_way_1)
    );

    // ----------------------------------------------------------------------
    // response registers, one cycle after the request
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_vld_0 <= 1'b0;
            resp_vld_1 <= 1'b0;
        end else begin
            resp_vld_0 <= req_vld_0;
            resp_vld_1 <= req_vld_1;
        end
    end

    always_ff @(posedge clk) begin
        resp_hit_0 <= hit_0;
        resp_hit_1 <= hit_1;
        resp_way_0 <= hit_0 ? hit_way_0 : victim_way_0;
        resp_way_1 <= hit_1 ? hit_way_1 : victim_way_1;
    end

    // both ports on one set with one tag would install the tag twice
    a_no_dup_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req_vld_0 && req_vld_1 && (req_index_0 == req_index_1) && (req_tag_0 == req_tag_1))
    ) else $error("%0t cache_dir_top: same set and tag on both ports", $time);

    a_resp_0: assert property (@(posedge clk) disable iff (!rst_n) req_vld_0 |=> resp_vld_0);
    a_resp_1: assert property (@(posedge clk) disable iff (!rst_n) req_vld_1 |=> resp_vld_1);

    a_quiet_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!resp_vld_0 && !resp_vld_1)
    ) else $error("%0t cache_dir_top: response valid out of reset", $time);

endmodule

`default_nettype wire

//--- include/tb_cache_dir_tasks.svh
`ifndef TB_CACHE_DIR_TASKS_SVH
`define TB_CACHE_DIR_TASKS_SVH
`default_nettype none

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic check_vld(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error %0t: %s valid %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_hit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error %0t: %s hit %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_way(input logic [way_width-1:0] got, input logic [way_width-1:0] exp,
                         input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error %0t: %s way %0d, expected %0d", $time, what, got, exp);
    end
endtask

// ----------------------------------------------------------------------
// model update
// ----------------------------------------------------------------------
task automatic model_lookup(input logic [index_width-1:0] idx, input logic [tag_width-1:0] tag,
                            output logic hit, output logic [way_width-1:0] way);
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < way_num; w++) begin
        if (m_valid[idx][w] && (m_tag[idx][w] == tag)) begin
            hit = 1'b1;
            way = way_width'(w);
        end
    end
endtask

// single aging steps until a scanned way reaches the maximum
task automatic age_and_pick(input logic excl_en, input logic [way_width-1:0] excl_way,
                            output logic [way_width-1:0] victim);
    logic found;
    found  = 1'b0;
    victim = '0;
    while (!found) begin
        for (int w = way_num - 1; w >= 0; w--) begin
            if (!(excl_en && excl_way == way_width'(w)) && work_rrpv[w] == rrpv_max) begin
                victim = way_width'(w);               // lowest way wins
                found  = 1'b1;
            end
        end
        if (!found) begin
            for (int w = 0; w < way_num; w++) begin
                if (!(excl_en && excl_way == way_width'(w))) begin
                    work_rrpv[w] = work_rrpv[w] + rrpv_width'(1);
                end
            end
        end
    end
endtask

task automatic update_port(input logic [index_width-1:0] idx, input logic [tag_width-1:0] tag,
                           input logic hit, input logic [way_width-1:0] hit_way,
                           input logic excl_en, input logic [way_width-1:0] excl_way,
                           output logic [way_width-1:0] way);
    for (int w = 0; w < way_num; w++) begin
        work_rrpv[w] = m_rrpv[idx][w];
    end
    if (hit) begin
        way                = hit_way;
        work_rrpv[hit_way] = '0;
    end else begin
        age_and_pick(excl_en, excl_way, way);
        work_rrpv[way]    = rrpv_insert;
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way]   = tag;
    end
    for (int w = 0; w < way_num; w++) begin
        m_rrpv[idx][w] = work_rrpv[w];
    end
endtask

// ----------------------------------------------------------------------
// drivers, called on a falling edge
// ----------------------------------------------------------------------
task automatic apply_reset();
    rst_n     = 1'b0;
    req_vld_0 = 1'b0;
    req_vld_1 = 1'b0;
    for (int s = 0; s < set_num; s++) begin
        for (int w = 0; w < way_num; w++) begin
            m_valid[s][w] = 1'b0;
            m_tag[s][w]   = '0;
            m_rrpv[s][w]  = rrpv_max;
        end
    end
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
endtask

task automatic run_cycle(input logic v0, input logic [index_width-1:0] i0,
                         input logic [tag_width-1:0] t0, input logic v1,
                         input logic [index_width-1:0] i1, input logic [tag_width-1:0] t1);
    logic                 hit0;
    logic                 hit1;
    logic [way_width-1:0] hw0;
    logic [way_width-1:0] hw1;
    logic [way_width-1:0] way0;
    logic [way_width-1:0] way1;
    req_vld_0   = v0;
    req_index_0 = i0;
    req_tag_0   = t0;
    req_vld_1   = v1;
    req_index_1 = i1;
    req_tag_1   = t1;
    model_lookup(i0, t0, hit0, hw0);                  // both ports see the old state
    model_lookup(i1, t1, hit1, hw1);
    way0 = '0;
    way1 = '0;
    if (v0) begin
        update_port(i0, t0, hit0, hw0, 1'b0, '0, way0);
    end
    if (v1) begin
        update_port(i1, t1, hit1, hw1, v0 && !hit0 && (i0 == i1), way0, way1);
    end
    @(posedge clk);
    @(negedge clk);
    check_vld(resp_vld_0, v0, "port 0");
    check_vld(resp_vld_1, v1, "port 1");
    if (v0) begin
        check_hit(resp_hit_0, hit0, "port 0");
        check_way(resp_way_0, way0, "port 0");
    end
    if (v1) begin
        check_hit(resp_hit_1, hit1, "port 1");
        check_way(resp_way_1, way1, "port 1");
    end
endtask

task automatic idle_cycle();
    run_cycle(1'b0, '0, '0, 1'b0, '0, '0);
endtask

task automatic port0_req(input logic [index_width-1:0] idx, input logic [tag_width-1:0] tag,
                         input logic exp_hit, input logic [way_width-1:0] exp_way);
    run_cycle(1'b1, idx, tag, 1'b0, '0, '0);
    check_hit(resp_hit_0, exp_hit, "directed port 0");
    check_way(resp_way_0, exp_way, "directed port 0");
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------
task automatic reset_behavior();
    apply_reset();
    repeat (4) idle_cycle();
    for (int s = 0; s < set_num; s += 2) begin
        rng = xorshift(rng);
        run_cycle(1'b1, index_width'(s), rng[11:0], 1'b1, index_width'(s + 1), rng[23:12]);
        check_way(resp_way_0, '0, "first miss port 0");
        check_way(resp_way_1, '0, "first miss port 1");
    end
    idle_cycle();
endtask

task automatic cold_fill();
    apply_reset();
    for (int w = 0; w < way_num; w++) begin
        port0_req(index_width'(5), 12'h101 + tag_width'(w), 1'b0, way_width'(w));
    end
    for (int w = 0; w < way_num; w++) begin
        port0_req(index_width'(5), 12'h101 + tag_width'(w), 1'b1, way_width'(w));
    end
    idle_cycle();
endtask

task automatic aging_evicts_way0();
    apply_reset();
    for (int w = 0; w < way_num; w++) begin
        port0_req(index_width'(7), 12'h111 + tag_width'(w), 1'b0, way_width'(w));
    end
    port0_req(index_width'(7), 12'h1ee, 1'b0, way_width'(0));   // whole set aged
    port0_req(index_width'(7), 12'h111, 1'b0, way_width'(1));   // evicted tag is gone
    idle_cycle();
endtask

task automatic promoted_line_survives();
    apply_reset();
    for (int w = 0; w < way_num; w++) begin
        port0_req(index_width'(11), 12'h301 + tag_width'(w), 1'b0, way_width'(w));
    end
    port0_req(index_width'(11), 12'h302, 1'b1, way_width'(1));
    port0_req(index_width'(11), 12'h305, 1'b0, way_width'(0));
    port0_req(index_width'(11), 12'h306, 1'b0, way_width'(2));
    port0_req(index_width'(11), 12'h307, 1'b0, way_width'(3));
    port0_req(index_width'(11), 12'h308, 1'b0, way_width'(0));
    port0_req(index_width'(11), 12'h302, 1'b1, way_width'(1));
    idle_cycle();
endtask

task automatic same_set_double_miss();
    apply_reset();
    run_cycle(1'b1, index_width'(9), 12'h201, 1'b1, index_width'(9), 12'h202);
    check_way(resp_way_1, way_width'(1), "double miss port 1");
    if (resp_way_0 === resp_way_1) begin
        error_count++;
        $display("error %0t: both ports installed into way %0d", $time, resp_way_0);
    end
    run_cycle(1'b1, index_width'(9), 12'h201, 1'b1, index_width'(9), 12'h202);
    port0_req(index_width'(9), 12'h203, 1'b0, way_width'(2));
    port0_req(index_width'(9), 12'h204, 1'b0, way_width'(3));
    run_cycle(1'b1, index_width'(9), 12'h205, 1'b1, index_width'(9), 12'h206);
    check_way(resp_way_0, way_width'(2), "aged double miss port 0");
    check_way(resp_way_1, way_width'(3), "aged double miss port 1");
    run_cycle(1'b1, index_width'(9), 12'h205, 1'b1, index_width'(9), 12'h206);
    idle_cycle();
endtask

task automatic random_traffic();
    logic [tag_width-1:0] t1;
    apply_reset();
    for (int n = 0; n < random_cycles; n++) begin
        rng = xorshift(rng);
        t1  = {9'h014, rng[11:9]};
        if ((rng[1:0] != 2'b00) && (rng[3:2] != 2'b00) && (rng[5:4] == rng[13:12])
            && (rng[8:6] == rng[11:9])) begin
            t1 = t1 ^ 12'h001;                        // keep the pair legal
        end
        run_cycle(rng[1:0] != 2'b00, {4'h4, rng[5:4]}, {9'h014, rng[8:6]},
                  rng[3:2] != 2'b00, {4'h4, rng[13:12]}, t1);
    end
    idle_cycle();
endtask

`default_nettype wire
`endif

//--- bench/tb_cache_dir.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_dir;
    import cache_dir_pkg::*;

    localparam int reset_cycles  = 5;
    localparam int random_cycles = 400;
    // each test is a reset, its own requests and one closing idle cycle
    localparam int test_cycles   = 6 * reset_cycles + (4 + set_num / 2 + 1) + 9 + 7 + 11 + 7
                                   + (random_cycles + 1);
    localparam int cycle_limit   = 2 * test_cycles;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_vld_0;
    logic [index_width-1:0] req_index_0;
    logic [tag_width-1:0]   req_tag_0;
    logic                   req_vld_1;
    logic [index_width-1:0] req_index_1;
    logic [tag_width-1:0]   req_tag_1;
    logic                   resp_vld_0;
    logic                   resp_hit_0;
    logic [way_width-1:0]   resp_way_0;
    logic                   resp_vld_1;
    logic                   resp_hit_1;
    logic [way_width-1:0]   resp_way_1;

    logic [31:0]            rng;
    int                     error_count;
    int                     check_count;
    int                     cycle_count;

    // ----------------------------------------------------------------------
    // reference model of the directory
    // ----------------------------------------------------------------------
    logic                   m_valid   [set_num][way_num];
    logic [tag_width-1:0]   m_tag     [set_num][way_num];
    logic [rrpv_width-1:0]  m_rrpv    [set_num][way_num];
    logic [rrpv_width-1:0]  work_rrpv [way_num];       // one set while it is updated

    cache_dir_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vld_0   (req_vld_0),
        .req_index_0 (req_index_0),
        .req_tag_0   (req_tag_0),
        .req_vld_1   (req_vld_1),
        .req_index_1 (req_index_1),
        .req_tag_1   (req_tag_1),
        .resp_vld_0  (resp_vld_0),
        .resp_hit_0  (resp_hit_0),
        .resp_way_0  (resp_way_0),
        .resp_vld_1  (resp_vld_1),
        .resp_hit_1  (resp_hit_1),
        .resp_way_1  (resp_way_1)
    );

    `include "tb_cache_dir_tasks.svh"

    initial begin
        forever #50 clk = ~clk;                      // 100 ns period
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        req_vld_0   = 1'b0;
        req_index_0 = '0;
        req_tag_0   = '0;
        req_vld_1   = 1'b0;
        req_index_1 = '0;
        req_tag_1   = '0;
        rng         = 32'd82407;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        reset_behavior();
        cold_fill();
        aging_evicts_way0();
        promoted_line_survives();
        same_set_double_miss();
        random_traffic();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hdl/cache_dir_pkg.sv
hdl/tag_store.sv
hdl/tag_match.sv
hdl/srrip_policy.sv
hdl/cache_dir_top.sv
bench/tb_cache_dir.sv

//--- Makefile
# Verilator flow for the cache directory testbench

TOP = tb_cache_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

# the run fails unless the pass line shows up in the output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
